// ==== verilog/cps_video_pkg.sv ====
package cps_video_pkg;

    // Raster geometry, counted in pixel enables and lines
    localparam int H_TOTAL      = 512;
    localparam int H_ACT_START  = 64;
    localparam int H_ACT_END    = 447;
    localparam int H_SYNC_START = 464;
    localparam int H_SYNC_END   = 495;

    localparam int V_TOTAL      = 262;
    localparam int V_ACT_START  = 16;
    localparam int V_ACT_END    = 239;
    localparam int V_SYNC_START = 244;
    localparam int V_SYNC_END   = 246;

    typedef logic [8:0] hcnt_t;
    typedef logic [8:0] vcnt_t;

    // Layer pixel is colour in 9:4, pen in 3:0
    typedef logic [9:0] layer_pxl_t;
    localparam logic [3:0] PEN_CLEAR = 4'd15;

    // 0 object, 1..3 scroll layers
    typedef logic [1:0] layer_id_t;
    localparam layer_id_t LAYER_OBJ = 2'd0;

    typedef logic [11:0] pal_addr_t;
    localparam int PAL_DEPTH = 4096;

    // Brightness, red, green, blue nibbles from the top
    typedef logic [15:0] pal_word_t;
    typedef logic [7:0]  color_t;

    // Layer input to RGB output, also the blanking delay
    localparam int BLNK_DLY = 3;

    typedef logic [4:0]  reg_addr_t;
    typedef logic [15:0] data_t;

    localparam reg_addr_t REG_PPU_CTRL   = 5'd0;
    localparam reg_addr_t REG_LAYER_CTRL = 5'd1;
    localparam reg_addr_t REG_RASTER     = 5'd2;
    localparam reg_addr_t REG_PAL_ADDR   = 5'd3;
    localparam reg_addr_t REG_PAL_DATA   = 5'd4;

endpackage

// ==== verilog/cps_timing.sv ====
module cps_timing (
    input  logic                  clk,
    input  logic                  rst,
    input  logic                  pxl_cen,
    output cps_video_pkg::hcnt_t  hdump,
    output cps_video_pkg::vcnt_t  vdump,
    output logic                  HB,
    output logic                  VB,
    output logic                  HS,
    output logic                  VS
);

    cps_video_pkg::hcnt_t h_nxt;
    cps_video_pkg::vcnt_t v_nxt;
    logic                 h_wrap;

    assign h_wrap = (hdump == cps_video_pkg::hcnt_t'(cps_video_pkg::H_TOTAL - 1));

    // Next counts, flags are decoded from these so they register in step
    always_comb begin
        h_nxt = hdump + 1'b1;
        v_nxt = vdump;
        if (h_wrap) begin
            h_nxt = '0;
            if (vdump == cps_video_pkg::vcnt_t'(cps_video_pkg::V_TOTAL - 1)) begin
                v_nxt = '0;
            end else begin
                v_nxt = vdump + 1'b1;
            end
        end
    end

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            hdump <= '0;
            vdump <= '0;
            // Count zero sits in both blanking intervals
            HB    <= 1'b1;
            VB    <= 1'b1;
            HS    <= 1'b0;
            VS    <= 1'b0;
        end else if (pxl_cen) begin
            hdump <= h_nxt;
            vdump <= v_nxt;
            HB    <= (h_nxt < cps_video_pkg::H_ACT_START) ||
                     (h_nxt > cps_video_pkg::H_ACT_END);
            VB    <= (v_nxt < cps_video_pkg::V_ACT_START) ||
                     (v_nxt > cps_video_pkg::V_ACT_END);
            HS    <= (h_nxt >= cps_video_pkg::H_SYNC_START) &&
                     (h_nxt <= cps_video_pkg::H_SYNC_END);
            VS    <= (v_nxt >= cps_video_pkg::V_SYNC_START) &&
                     (v_nxt <= cps_video_pkg::V_SYNC_END);
        end
    end

    // Line count stays inside the frame
    a_vdump_range: assert property (
        @(posedge clk) disable iff (rst)
        vdump < cps_video_pkg::V_TOTAL
    ) else $error("vdump left the frame");

endmodule

// ==== verilog/cps_mmr.sv ====
module cps_mmr (
    input  logic                      clk,
    input  logic                      rst,
    input  logic                      pxl_cen,
    input  logic                      ppu_cs,
    input  logic                      cpu_rnw,
    input  cps_video_pkg::reg_addr_t  addr,
    input  logic [1:0]                dsn,
    input  cps_video_pkg::data_t      cpu_dout,
    output cps_video_pkg::data_t      mmr_dout,
    input  cps_video_pkg::vcnt_t      vdump,
    output logic [2:0]                scr_en,
    output logic [7:0]                layer_order,
    output logic                      raster,
    output logic                      pal_we,
    output cps_video_pkg::pal_addr_t  pal_waddr,
    output cps_video_pkg::pal_word_t  pal_wdata
);

    cps_video_pkg::data_t     ppu_ctrl;
    cps_video_pkg::data_t     layer_ctrl;
    cps_video_pkg::data_t     raster_ctrl;
    cps_video_pkg::pal_addr_t pal_ptr;
    logic                     cpu_wr;
    logic                     cpu_rd;
    logic                     pal_port_wr;

    assign cpu_wr      = ppu_cs && !cpu_rnw;
    assign cpu_rd      = ppu_cs && cpu_rnw;
    assign pal_port_wr = cpu_wr && (addr == cps_video_pkg::REG_PAL_DATA);

    assign scr_en      = ppu_ctrl[3:1];
    assign layer_order = layer_ctrl[7:0];

    // dsn[1] is the upper byte strobe
    function automatic cps_video_pkg::data_t lane_merge(
        input cps_video_pkg::data_t cur,
        input cps_video_pkg::data_t din,
        input logic [1:0]           lanes
    );
        cps_video_pkg::data_t res;
        res = cur;
        if (!lanes[1]) res[15:8] = din[15:8];
        if (!lanes[0]) res[7:0] = din[7:0];
        return res;
    endfunction

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            ppu_ctrl    <= '0;
            layer_ctrl  <= '0;
            raster_ctrl <= '0;
            pal_ptr     <= '0;
            pal_we      <= 1'b0;
        end else begin
            pal_we <= pal_port_wr;
            if (cpu_wr) begin
                case (addr)
                    cps_video_pkg::REG_PPU_CTRL:
                        ppu_ctrl <= lane_merge(ppu_ctrl, cpu_dout, dsn);
                    cps_video_pkg::REG_LAYER_CTRL:
                        layer_ctrl <= lane_merge(layer_ctrl, cpu_dout, dsn);
                    cps_video_pkg::REG_RASTER:
                        raster_ctrl <= lane_merge(raster_ctrl, cpu_dout, dsn);
                    cps_video_pkg::REG_PAL_ADDR:
                        pal_ptr <= cps_video_pkg::pal_addr_t'(
                            lane_merge(cps_video_pkg::data_t'(pal_ptr), cpu_dout, dsn));
                    // Pointer wraps at the palette size by its width
                    cps_video_pkg::REG_PAL_DATA:
                        pal_ptr <= pal_ptr + 1'b1;
                    default: ;
                endcase
            end
        end
    end

    // Palette write payload, launched with pal_we
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            pal_waddr <= '0;
            pal_wdata <= '0;
        end else if (pal_port_wr) begin
            pal_waddr <= pal_ptr;
            pal_wdata <= cpu_dout;
        end
    end

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            mmr_dout <= '0;
        end else if (cpu_rd) begin
            case (addr)
                cps_video_pkg::REG_PPU_CTRL:   mmr_dout <= ppu_ctrl;
                cps_video_pkg::REG_LAYER_CTRL: mmr_dout <= layer_ctrl;
                cps_video_pkg::REG_RASTER:     mmr_dout <= raster_ctrl;
                cps_video_pkg::REG_PAL_ADDR:   mmr_dout <= cps_video_pkg::data_t'(pal_ptr);
                default:                       mmr_dout <= '0;
            endcase
        end
    end

    // Line match against the raster register, bit 9 enables it
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            raster <= 1'b0;
        end else if (pxl_cen) begin
            raster <= raster_ctrl[9] && (vdump == raster_ctrl[8:0]);
        end
    end

    // A palette write leaves the pointer one past the written entry
    a_pal_we_src: assert property (
        @(posedge clk) disable iff (rst)
        pal_we |-> (pal_ptr == cps_video_pkg::pal_addr_t'(pal_waddr + 1'b1))
    ) else $error("palette write issued without a pointer step");

endmodule

// ==== verilog/cps_colmix.sv ====
module cps_colmix (
    input  logic                       clk,
    input  logic                       rst,
    input  logic                       pxl_cen,
    input  logic [2:0]                 scr_en,
    input  logic [7:0]                 layer_order,
    input  cps_video_pkg::layer_pxl_t  obj_pxl,
    input  cps_video_pkg::layer_pxl_t  scr1_pxl,
    input  cps_video_pkg::layer_pxl_t  scr2_pxl,
    input  cps_video_pkg::layer_pxl_t  scr3_pxl,
    output cps_video_pkg::pal_addr_t   pal_addr
);

    cps_video_pkg::layer_id_t  sel_id;
    cps_video_pkg::layer_pxl_t sel_pxl;

    function automatic cps_video_pkg::layer_pxl_t layer_pixel(
        input cps_video_pkg::layer_id_t id
    );
        cps_video_pkg::layer_pxl_t res;
        case (id)
            2'd1:    res = scr1_pxl;
            2'd2:    res = scr2_pxl;
            2'd3:    res = scr3_pxl;
            default: res = obj_pxl;
        endcase
        return res;
    endfunction

    // Objects cannot be switched off
    function automatic logic layer_on(input cps_video_pkg::layer_id_t id);
        logic res;
        if (id == cps_video_pkg::LAYER_OBJ) begin
            res = 1'b1;
        end else begin
            res = scr_en[id - 2'd1];
        end
        return res;
    endfunction

    // Walk bottom to top so the highest qualifying slot wins
    always_comb begin
        cps_video_pkg::layer_id_t  slot_id;
        cps_video_pkg::layer_pxl_t slot_pxl;
        sel_id  = layer_order[1:0];
        sel_pxl = layer_pixel(layer_order[1:0]);
        for (int i = 0; i < 4; i++) begin
            slot_id  = layer_order[2*i +: 2];
            slot_pxl = layer_pixel(slot_id);
            if (layer_on(slot_id) && slot_pxl[3:0] != cps_video_pkg::PEN_CLEAR) begin
                sel_id  = slot_id;
                sel_pxl = slot_pxl;
            end
        end
    end

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            pal_addr <= '0;
        end else if (pxl_cen) begin
            pal_addr <= {sel_id, sel_pxl};
        end
    end

endmodule

// ==== verilog/cps_pal.sv ====
module cps_pal (
    input  logic                      clk,
    input  logic                      rst,
    input  logic                      pxl_cen,
    input  logic                      pal_we,
    input  cps_video_pkg::pal_addr_t  pal_waddr,
    input  cps_video_pkg::pal_word_t  pal_wdata,
    input  cps_video_pkg::pal_addr_t  pal_addr,
    input  logic                      HB,
    input  logic                      VB,
    output cps_video_pkg::color_t     red,
    output cps_video_pkg::color_t     green,
    output cps_video_pkg::color_t     blue,
    output logic                      LHBL_dly,
    output logic                      LVBL_dly
);

    localparam int DLY = cps_video_pkg::BLNK_DLY;

    cps_video_pkg::pal_word_t pal_ram [cps_video_pkg::PAL_DEPTH];
    cps_video_pkg::pal_word_t pal_q;
    logic [DLY-1:0]           hb_sr;
    logic [DLY-1:0]           vb_sr;
    logic                     blank_mid;

    // Channel gain runs 1 to 16, so 15 * 16 still fits in eight bits
    function automatic cps_video_pkg::color_t scale(
        input logic [3:0] nib,
        input logic [3:0] bri
    );
        cps_video_pkg::color_t gain;
        gain = cps_video_pkg::color_t'(bri) + 8'd1;
        return cps_video_pkg::color_t'(nib) * gain;
    endfunction

    always_ff @(posedge clk) begin
        if (pal_we) begin
            pal_ram[pal_waddr] <= pal_wdata;
        end
        if (pxl_cen) begin
            pal_q <= pal_ram[pal_addr];
        end
    end

    // Blank flag that lines up with pal_q
    assign blank_mid = hb_sr[DLY-2] || vb_sr[DLY-2];

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            hb_sr <= '1;
            vb_sr <= '1;
            red   <= '0;
            green <= '0;
            blue  <= '0;
        end else if (pxl_cen) begin
            hb_sr <= {hb_sr[DLY-2:0], HB};
            vb_sr <= {vb_sr[DLY-2:0], VB};
            if (blank_mid) begin
                red   <= '0;
                green <= '0;
                blue  <= '0;
            end else begin
                red   <= scale(pal_q[11:8], pal_q[15:12]);
                green <= scale(pal_q[7:4],  pal_q[15:12]);
                blue  <= scale(pal_q[3:0],  pal_q[15:12]);
            end
        end
    end

    assign LHBL_dly = ~hb_sr[DLY-1];
    assign LVBL_dly = ~vb_sr[DLY-1];

endmodule

// ==== verilog/cps_video.sv ====
module cps_video (
    input  logic                       clk,
    input  logic                       rst,
    input  logic                       pxl_cen,
    // CPU side
    input  logic                       ppu_cs,
    input  logic                       cpu_rnw,
    input  cps_video_pkg::reg_addr_t   addr,
    input  logic [1:0]                 dsn,
    input  cps_video_pkg::data_t       cpu_dout,
    output cps_video_pkg::data_t       mmr_dout,
    // Layer pixels, one per pixel enable
    input  cps_video_pkg::layer_pxl_t  obj_pxl,
    input  cps_video_pkg::layer_pxl_t  scr1_pxl,
    input  cps_video_pkg::layer_pxl_t  scr2_pxl,
    input  cps_video_pkg::layer_pxl_t  scr3_pxl,
    // Video out
    output cps_video_pkg::hcnt_t       hdump,
    output cps_video_pkg::vcnt_t       vdump,
    output logic                       HS,
    output logic                       VS,
    output logic                       HB,
    output logic                       VB,
    output logic                       LHBL_dly,
    output logic                       LVBL_dly,
    output logic                       raster,
    output cps_video_pkg::color_t      red,
    output cps_video_pkg::color_t      green,
    output cps_video_pkg::color_t      blue
);

    logic [2:0]                  scr_en;
    logic [7:0]                  layer_order;
    logic                        pal_we;
    cps_video_pkg::pal_addr_t    pal_waddr;
    cps_video_pkg::pal_word_t    pal_wdata;
    cps_video_pkg::pal_addr_t    pal_addr;

    cps_timing u_timing (
        .clk         ( clk         ),
        .rst         ( rst         ),
        .pxl_cen     ( pxl_cen     ),
        .hdump       ( hdump       ),
        .vdump       ( vdump       ),
        .HB          ( HB          ),
        .VB          ( VB          ),
        .HS          ( HS          ),
        .VS          ( VS          )
    );

    cps_mmr u_mmr (
        .clk         ( clk         ),
        .rst         ( rst         ),
        .pxl_cen     ( pxl_cen     ),
        .ppu_cs      ( ppu_cs      ),
        .cpu_rnw     ( cpu_rnw     ),
        .addr        ( addr        ),
        .dsn         ( dsn         ),
        .cpu_dout    ( cpu_dout    ),
        .mmr_dout    ( mmr_dout    ),
        .vdump       ( vdump       ),
        .scr_en      ( scr_en      ),
        .layer_order ( layer_order ),
        .raster      ( raster      ),
        .pal_we      ( pal_we      ),
        .pal_waddr   ( pal_waddr   ),
        .pal_wdata   ( pal_wdata   )
    );

    cps_colmix u_colmix (
        .clk         ( clk         ),
        .rst         ( rst         ),
        .pxl_cen     ( pxl_cen     ),
        .scr_en      ( scr_en      ),
        .layer_order ( layer_order ),
        .obj_pxl     ( obj_pxl     ),
        .scr1_pxl    ( scr1_pxl    ),
        .scr2_pxl    ( scr2_pxl    ),
        .scr3_pxl    ( scr3_pxl    ),
        .pal_addr    ( pal_addr    )
    );

    cps_pal u_pal (
        .clk         ( clk         ),
        .rst         ( rst         ),
        .pxl_cen     ( pxl_cen     ),
        .pal_we      ( pal_we      ),
        .pal_waddr   ( pal_waddr   ),
        .pal_wdata   ( pal_wdata   ),
        .pal_addr    ( pal_addr    ),
        .HB          ( HB          ),
        .VB          ( VB          ),
        .red         ( red         ),
        .green       ( green       ),
        .blue        ( blue        ),
        .LHBL_dly    ( LHBL_dly    ),
        .LVBL_dly    ( LVBL_dly    )
    );

endmodule

// ==== tb/cps_video_tb.sv ====
module cps_video_tb;

    timeunit 1ns;
    timeprecision 1ps;

    localparam int CLK_PERIOD = 40;
    localparam int DLY        = cps_video_pkg::BLNK_DLY;
    // One frame in clocks, pixel enable on every other clock
    localparam int FRAME_CLKS = 2 * cps_video_pkg::H_TOTAL * cps_video_pkg::V_TOTAL;

    logic                      clk, rst, pxl_cen, ppu_cs, cpu_rnw;
    cps_video_pkg::reg_addr_t  addr;
    logic [1:0]                dsn;
    cps_video_pkg::data_t      cpu_dout, mmr_dout;
    cps_video_pkg::layer_pxl_t obj_pxl, scr1_pxl, scr2_pxl, scr3_pxl;
    cps_video_pkg::hcnt_t      hdump;
    cps_video_pkg::vcnt_t      vdump;
    logic                      HS, VS, HB, VB, LHBL_dly, LVBL_dly, raster;
    cps_video_pkg::color_t     red, green, blue;

    integer                    seed;
    int                        mismatches;
    int                        failures;
    logic                      pix_chk;

    // Reference model state
    cps_video_pkg::hcnt_t      exp_h;
    cps_video_pkg::vcnt_t      exp_v;
    cps_video_pkg::data_t      m_ctrl, m_layer, m_rast, exp_dout;
    cps_video_pkg::pal_addr_t  m_ptr;
    cps_video_pkg::pal_word_t  m_pal [cps_video_pkg::PAL_DEPTH];
    logic                      exp_raster;
    logic [23:0]               rgb_now;
    logic [DLY-1:0]            pipe_v, pipe_hb, pipe_vb;
    logic [DLY-1:0][23:0]      pipe_rgb;

    cps_video i_cps_video (.*);

    initial begin
        clk = 1'b0;
        forever #(CLK_PERIOD / 2) clk = ~clk;
    end

    function automatic logic hblank_at(input cps_video_pkg::hcnt_t h);
        return (h < cps_video_pkg::H_ACT_START) || (h > cps_video_pkg::H_ACT_END);
    endfunction

    function automatic logic vblank_at(input cps_video_pkg::vcnt_t v);
        return (v < cps_video_pkg::V_ACT_START) || (v > cps_video_pkg::V_ACT_END);
    endfunction

    function automatic logic hsync_at(input cps_video_pkg::hcnt_t h);
        return (h >= cps_video_pkg::H_SYNC_START) && (h <= cps_video_pkg::H_SYNC_END);
    endfunction

    function automatic logic vsync_at(input cps_video_pkg::vcnt_t v);
        return (v >= cps_video_pkg::V_SYNC_START) && (v <= cps_video_pkg::V_SYNC_END);
    endfunction

    // Low dsn bit enables its byte lane
    function automatic cps_video_pkg::data_t merge_bytes(input cps_video_pkg::data_t cur,
                                                         input cps_video_pkg::data_t din,
                                                         input logic [1:0] lanes);
        cps_video_pkg::data_t mask;
        mask = {{8{~lanes[1]}}, {8{~lanes[0]}}};
        return (cur & ~mask) | (din & mask);
    endfunction

    function automatic cps_video_pkg::data_t read_value(input cps_video_pkg::reg_addr_t a);
        cps_video_pkg::data_t v;
        case (a)
            cps_video_pkg::REG_PPU_CTRL:   v = m_ctrl;
            cps_video_pkg::REG_LAYER_CTRL: v = m_layer;
            cps_video_pkg::REG_RASTER:     v = m_rast;
            cps_video_pkg::REG_PAL_ADDR:   v = {4'd0, m_ptr};
            default:                       v = '0;
        endcase
        return v;
    endfunction

    function automatic cps_video_pkg::layer_pxl_t layer_input(input cps_video_pkg::layer_id_t id);
        cps_video_pkg::layer_pxl_t px;
        case (id)
            2'd1:    px = scr1_pxl;
            2'd2:    px = scr2_pxl;
            2'd3:    px = scr3_pxl;
            default: px = obj_pxl;
        endcase
        return px;
    endfunction

    // Topmost slot with an enabled layer and an opaque pen, else the bottom slot
    function automatic cps_video_pkg::pal_addr_t pick_addr();
        cps_video_pkg::layer_id_t  id;
        cps_video_pkg::layer_pxl_t px;
        cps_video_pkg::pal_addr_t  res;
        logic                      found;
        found = 1'b0;
        res   = {m_layer[1:0], layer_input(m_layer[1:0])};
        for (int slot = 3; slot >= 0; slot--) begin
            id = m_layer[2*slot +: 2];
            px = layer_input(id);
            if (!found && (id == 2'd0 || m_ctrl[id]) && px[3:0] != cps_video_pkg::PEN_CLEAR) begin
                found = 1'b1;
                res   = {id, px};
            end
        end
        return res;
    endfunction

    function automatic logic [23:0] expected_rgb(input cps_video_pkg::pal_word_t w);
        int gain;
        int r;
        int g;
        int b;
        gain = int'(w[15:12]) + 1;
        r    = int'(w[11:8]) * gain;
        g    = int'(w[7:4]) * gain;
        b    = int'(w[3:0]) * gain;
        return {r[7:0], g[7:0], b[7:0]};
    endfunction

    // Roughly a quarter of the pens come out transparent
    function automatic cps_video_pkg::layer_pxl_t random_pixel();
        cps_video_pkg::layer_pxl_t px;
        px = cps_video_pkg::layer_pxl_t'($random(seed));
        if (($random(seed) & 3) == 0) begin
            px[3:0] = cps_video_pkg::PEN_CLEAR;
        end
        return px;
    endfunction

    always @(posedge clk or posedge rst) begin
        if (rst) begin
            exp_h      <= '0;
            exp_v      <= '0;
            m_ctrl     <= '0;
            m_layer    <= '0;
            m_rast     <= '0;
            m_ptr      <= '0;
            exp_dout   <= '0;
            exp_raster <= 1'b0;
            pipe_v     <= '0;
            pipe_hb    <= '1;
            pipe_vb    <= '1;
            pipe_rgb   <= '0;
        end else begin
            if (ppu_cs && !cpu_rnw) begin
                case (addr)
                    cps_video_pkg::REG_PPU_CTRL:   m_ctrl  <= merge_bytes(m_ctrl, cpu_dout, dsn);
                    cps_video_pkg::REG_LAYER_CTRL: m_layer <= merge_bytes(m_layer, cpu_dout, dsn);
                    cps_video_pkg::REG_RASTER:     m_rast  <= merge_bytes(m_rast, cpu_dout, dsn);
                    cps_video_pkg::REG_PAL_ADDR:
                        m_ptr <= cps_video_pkg::pal_addr_t'(
                            merge_bytes({4'd0, m_ptr}, cpu_dout, dsn));
                    cps_video_pkg::REG_PAL_DATA: begin
                        m_pal[m_ptr] <= cpu_dout;
                        m_ptr        <= m_ptr + 1'b1;
                    end
                    default: ;
                endcase
            end
            if (ppu_cs && cpu_rnw) begin
                exp_dout <= read_value(addr);
            end
            if (pxl_cen) begin
                if (exp_h == cps_video_pkg::hcnt_t'(cps_video_pkg::H_TOTAL - 1)) begin
                    exp_h <= '0;
                    exp_v <= (exp_v == cps_video_pkg::vcnt_t'(cps_video_pkg::V_TOTAL - 1)) ?
                             '0 : exp_v + 1'b1;
                end else begin
                    exp_h <= exp_h + 1'b1;
                end
                exp_raster <= m_rast[9] && (exp_v == m_rast[8:0]);
                if (hblank_at(exp_h) || vblank_at(exp_v)) begin
                    rgb_now = '0;
                end else begin
                    rgb_now = expected_rgb(m_pal[pick_addr()]);
                end
                pipe_v   <= {pipe_v[DLY-2:0], pix_chk};
                pipe_hb  <= {pipe_hb[DLY-2:0], hblank_at(exp_h)};
                pipe_vb  <= {pipe_vb[DLY-2:0], vblank_at(exp_v)};
                pipe_rgb <= {pipe_rgb[DLY-2:0], rgb_now};
            end
        end
    end

    task automatic report_mismatch(input string name, input int exp_val, input int got_val);
        mismatches++;
        $display("MISMATCH t=%0t %s expected 0x%0h got 0x%0h", $time, name, exp_val, got_val);
    endtask

    a_hdump: assert property (@(posedge clk) disable iff (rst) hdump == exp_h)
        else report_mismatch("hdump", int'($sampled(exp_h)), int'($sampled(hdump)));
    a_vdump: assert property (@(posedge clk) disable iff (rst) vdump == exp_v)
        else report_mismatch("vdump", int'($sampled(exp_v)), int'($sampled(vdump)));
    a_hb: assert property (@(posedge clk) disable iff (rst) HB == hblank_at(exp_h))
        else report_mismatch("HB", int'(hblank_at($sampled(exp_h))), int'($sampled(HB)));
    a_vb: assert property (@(posedge clk) disable iff (rst) VB == vblank_at(exp_v))
        else report_mismatch("VB", int'(vblank_at($sampled(exp_v))), int'($sampled(VB)));
    a_hs: assert property (@(posedge clk) disable iff (rst) HS == hsync_at(exp_h))
        else report_mismatch("HS", int'(hsync_at($sampled(exp_h))), int'($sampled(HS)));
    a_vs: assert property (@(posedge clk) disable iff (rst) VS == vsync_at(exp_v))
        else report_mismatch("VS", int'(vsync_at($sampled(exp_v))), int'($sampled(VS)));
    a_dout: assert property (@(posedge clk) disable iff (rst) mmr_dout == exp_dout)
        else report_mismatch("mmr_dout", int'($sampled(exp_dout)), int'($sampled(mmr_dout)));
    a_raster: assert property (@(posedge clk) disable iff (rst) raster == exp_raster)
        else report_mismatch("raster", int'($sampled(exp_raster)), int'($sampled(raster)));
    a_lhbl: assert property (@(posedge clk) disable iff (rst) LHBL_dly == !pipe_hb[DLY-1])
        else report_mismatch("LHBL_dly", int'(!$sampled(pipe_hb[DLY-1])), int'($sampled(LHBL_dly)));
    a_lvbl: assert property (@(posedge clk) disable iff (rst) LVBL_dly == !pipe_vb[DLY-1])
        else report_mismatch("LVBL_dly", int'(!$sampled(pipe_vb[DLY-1])), int'($sampled(LVBL_dly)));
    a_rgb: assert property (@(posedge clk) disable iff (rst)
        pipe_v[DLY-1] |-> {red, green, blue} == pipe_rgb[DLY-1])
        else report_mismatch("rgb", int'($sampled(pipe_rgb[DLY-1])),
                             int'({$sampled(red), $sampled(green), $sampled(blue)}));
    a_black: assert property (@(posedge clk) disable iff (rst)
        (!LHBL_dly || !LVBL_dly) |-> {red, green, blue} == 24'd0)
        else report_mismatch("rgb in blanking", 0,
                             int'({$sampled(red), $sampled(green), $sampled(blue)}));

    // Pixel enable and layer pixels, new pixels with each enable
    initial begin
        pxl_cen  = 1'b0;
        obj_pxl  = '0;
        scr1_pxl = '0;
        scr2_pxl = '0;
        scr3_pxl = '0;
        forever begin
            @(negedge clk);
            pxl_cen = ~pxl_cen;
            if (pxl_cen) begin
                obj_pxl  = random_pixel();
                scr1_pxl = random_pixel();
                scr2_pxl = random_pixel();
                scr3_pxl = random_pixel();
            end
        end
    end

    task automatic finish_run();
        $display("Errors: %0d mismatches, %0d other failures", mismatches, failures);
        if (mismatches + failures == 0) begin
            $display("Verification passed");
        end else begin
            $display("Verification failed");
        end
        $finish;
    endtask

    task automatic cpu_access(input logic rnw, input cps_video_pkg::reg_addr_t a,
                              input cps_video_pkg::data_t d, input logic [1:0] lanes);
        @(negedge clk);
        ppu_cs   = 1'b1;
        cpu_rnw  = rnw;
        addr     = a;
        dsn      = lanes;
        cpu_dout = d;
        @(negedge clk);
        ppu_cs   = 1'b0;
        cpu_rnw  = 1'b1;
        dsn      = 2'b11;
        @(posedge clk);
    endtask

    task automatic shuffle_layers();
        cpu_access(1'b0, cps_video_pkg::REG_PPU_CTRL, cps_video_pkg::data_t'($random(seed)), 2'b00);
        cpu_access(1'b0, cps_video_pkg::REG_LAYER_CTRL, cps_video_pkg::data_t'($random(seed)), 2'b00);
    endtask

    task automatic wait_line(input cps_video_pkg::vcnt_t line);
        int n;
        n = 0;
        while (vdump != line && n < FRAME_CLKS + 4096) begin
            @(negedge clk);
            n++;
        end
        if (vdump != line) begin
            failures++;
            $display("Timeout at %0t: line %0d was not reached", $time, line);
        end else begin
            @(posedge clk);
        end
    endtask

    initial begin
        seed       = 32'h663fbdf0;
        mismatches = 0;
        failures   = 0;
        pix_chk    = 1'b0;
        rst        = 1'b1;
        ppu_cs     = 1'b0;
        cpu_rnw    = 1'b1;
        addr       = '0;
        dsn        = 2'b11;
        cpu_dout   = '0;
        repeat (16) @(posedge clk);
        @(negedge clk);
        rst = 1'b0;
        @(posedge clk);

        // Every dsn pattern on each register, read back right after
        for (int r = 0; r < 4; r++) begin
            for (int l = 0; l < 4; l++) begin
                cpu_access(1'b0, cps_video_pkg::reg_addr_t'(r),
                           cps_video_pkg::data_t'($random(seed)), 2'(l));
                cpu_access(1'b1, cps_video_pkg::reg_addr_t'(r), '0, 2'b00);
            end
        end

        // Pointer steps once per data-port write
        cpu_access(1'b0, cps_video_pkg::REG_PAL_ADDR, cps_video_pkg::data_t'($random(seed)), 2'b00);
        for (int n = 0; n < 5; n++) begin
            cpu_access(1'b0, cps_video_pkg::REG_PAL_DATA,
                       cps_video_pkg::data_t'($random(seed)), 2'b00);
        end
        cpu_access(1'b1, cps_video_pkg::REG_PAL_ADDR, '0, 2'b00);
        cpu_access(1'b1, cps_video_pkg::REG_PAL_DATA, '0, 2'b00);

        // Full palette load, the pointer wraps back to zero
        cpu_access(1'b0, cps_video_pkg::REG_PAL_ADDR, '0, 2'b00);
        for (int n = 0; n < cps_video_pkg::PAL_DEPTH; n++) begin
            cpu_access(1'b0, cps_video_pkg::REG_PAL_DATA,
                       cps_video_pkg::data_t'($random(seed)), 2'b00);
        end
        cpu_access(1'b1, cps_video_pkg::REG_PAL_ADDR, '0, 2'b00);

        cpu_access(1'b0, cps_video_pkg::REG_RASTER, 16'h0200 | 16'd40, 2'b00);
        shuffle_layers();
        @(negedge clk);
        pix_chk = 1'b1;
        @(posedge clk);

        wait_line(9'd50);
        // Line set but enable clear
        cpu_access(1'b0, cps_video_pkg::REG_RASTER, 16'd60, 2'b00);
        for (int l = 70; l < cps_video_pkg::V_TOTAL; l += 24) begin
            wait_line(cps_video_pkg::vcnt_t'(l));
            shuffle_layers();
        end
        cpu_access(1'b0, cps_video_pkg::REG_RASTER, 16'h0200 | 16'd5, 2'b00);
        wait_line(9'd0);
        wait_line(9'd12);
        finish_run();
    end

endmodule

// ==== cps_video.f ====
verilog/cps_video_pkg.sv
verilog/cps_timing.sv
verilog/cps_mmr.sv
verilog/cps_colmix.sv
verilog/cps_pal.sv
verilog/cps_video.sv
tb/cps_video_tb.sv

// ==== build.sh ====
#!/bin/sh
cd "$(dirname "$0")" || exit 1

rm -rf obj_dir
verilator --binary --timing --assert --timescale 1ns/1ps \
    --top-module cps_video_tb -f cps_video.f -o cps_video_sim > build.log 2>&1
status=$?
cat build.log
if [ $status -ne 0 ]; then
    echo "Verilator build returned status $status"
    exit 1
fi

./obj_dir/cps_video_sim > sim.log 2>&1
status=$?
cat sim.log
if [ $status -ne 0 ]; then
    echo "Simulation returned status $status"
    exit 1
fi

if grep -q "Verification failed" sim.log; then
    exit 1
fi
exit 0
